// ==== files.f ====
+incdir+logic
logic/ctrlPkg.sv
logic/instrDecoder.sv
logic/controlSequencer.sv
logic/datapathSelect.sv
logic/controlUnit.sv
testbench/wbMemModel.sv
testbench/controlUnitTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the control unit testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -j 0 --top-module controlUnitTb -f files.f
./obj_dir/VcontrolUnitTb | tee sim.log

if grep -q "^Verification passed$" sim.log
then
	echo "simulation result: pass"
else
	echo "simulation result: fail"
	exit 1
fi

// ==== testbench/controlUnitTb.sv ====
`include "ctrl_defs.svh"

module controlUnitTb;

	localparam int CycleLimit = 400; // ~24 words of up to 11 cycles, resets and halts

	logic clk;
	logic reset;
	logic [`OPCODE_W-1:0] opcode;
	logic [`FUNCT_W-1:0] funct;
	logic [`SHAMT_W-1:0] shamt;
	logic wbAck, wbCyc, wbStb, wbWe;
	logic irWrite, pcControl, mdrControl, writeA, writeB, aluSrcA;
	logic regAluControl, pcCond, bneOrBeq, regWrite;
	ctrlPkg::addrSel iorD;
	ctrlPkg::aluSrcBSel aluSrcB;
	ctrlPkg::aluOp aluControl;
	ctrlPkg::pcSource origPc;
	ctrlPkg::regDstSel regDst;
	ctrlPkg::memToRegSel memToReg;
	ctrlPkg::ctrlState state;

	// one entry per word loaded into the IR
	string names[$];
	logic [`OPCODE_W-1:0] opcodes[$];
	logic [`FUNCT_W-1:0] functs[$];
	logic [`SHAMT_W-1:0] shamts[$];
	ctrlPkg::ctrlState dispatch[$];
	logic [2:0] aluCodes[$];

	int curIdx = -1;
	int phaseEnd = 0;
	int errorCount = 0;
	int checkCount = 0;
	int cycleCount = 0;
	logic fetchDone = 1'b0;
	logic prevReset = 1'b1;
	logic prevAck = 1'b0;
	ctrlPkg::ctrlState prevState = ctrlPkg::ResetState;
	logic [22:0] outBits;

	assign outBits = {wbCyc, wbStb, wbWe, irWrite, pcControl, mdrControl, iorD, writeA, writeB,
		aluSrcA, aluSrcB, aluControl, regAluControl, pcCond, bneOrBeq, origPc, regWrite, regDst,
		memToReg};

	controlUnit u_dut (.*);

	wbMemModel #(.Seed(34294)) u_mem (.*);

	initial
	begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	always @(posedge clk)
	begin
		cycleCount++;
		if (cycleCount >= CycleLimit)
		begin
			$display("timeout: the run did not reach its end within %0d cycles", CycleLimit);
			$display("Verification failed");
			$finish;
		end
	end

	task automatic addInstr(input string name, input logic [`OPCODE_W-1:0] op,
		input logic [`FUNCT_W-1:0] fn, input logic [`SHAMT_W-1:0] sa,
		input ctrlPkg::ctrlState next, input logic [2:0] alu);
		names.push_back(name);
		opcodes.push_back(op);
		functs.push_back(fn);
		shamts.push_back(sa);
		dispatch.push_back(next);
		aluCodes.push_back(alu);
	endtask

	task automatic buildProgram();
		for (int k = 0; k < 2; k++)
		begin
			addInstr("add", `OP_RTYPE, `FN_ADD, 5'd0, ctrlPkg::AluExecute, 3'b001);
			addInstr("sub", `OP_RTYPE, `FN_SUB, 5'd0, ctrlPkg::AluExecute, 3'b010);
			addInstr("and", `OP_RTYPE, `FN_AND, 5'd0, ctrlPkg::AluExecute, 3'b011);
			addInstr("xor", `OP_RTYPE, `FN_XOR, 5'd0, ctrlPkg::AluExecute, 3'b110);
			addInstr("beq", `OP_BEQ, k ? 6'h15 : 6'h00, 5'd2, ctrlPkg::Branch, 3'b000);
			addInstr("bne", `OP_BNE, k ? 6'h2a : 6'h01, 5'd0, ctrlPkg::Branch, 3'b000);
			addInstr("lw", `OP_LW, k ? 6'h04 : 6'h00, 5'd0, ctrlPkg::LoadAddr, 3'b000);
			addInstr("sw", `OP_SW, k ? 6'h08 : 6'h00, 5'd1, ctrlPkg::StoreAddr, 3'b000);
			addInstr("j", `OP_J, k ? 6'h3f : 6'h10, 5'd7, ctrlPkg::Jump, 3'b000);
			addInstr("nop", `OP_RTYPE, `FN_SLL, 5'd0, ctrlPkg::Nop, 3'b000);
		end
		addInstr("sll 3", `OP_RTYPE, `FN_SLL, 5'd3, ctrlPkg::Halt, 3'b000); // not decoded
		phaseEnd = names.size() - 1;
		addInstr("nop", `OP_RTYPE, `FN_SLL, 5'd0, ctrlPkg::Nop, 3'b000);
		addInstr("break", `OP_RTYPE, `FN_BREAK, 5'd0, ctrlPkg::Halt, 3'b000);
	endtask

	function automatic string testName();
		if (curIdx < 0)
			return "reset";
		return names[curIdx];
	endfunction

	task automatic checkValue(input string what, input int expected, input int actual);
		checkCount++;
		assert (actual == expected)
		else
		begin
			errorCount++;
			$display("error %s %s: expected %0d, actual %0d", testName(), what, expected, actual);
		end
	endtask

	// state sequence as the instruction flow defines it
	function automatic ctrlPkg::ctrlState expectedNext();
		case (prevState)
			ctrlPkg::ResetState: return ctrlPkg::Fetch;
			ctrlPkg::Fetch: return prevAck ? ctrlPkg::Decode : ctrlPkg::Fetch;
			ctrlPkg::Decode: return dispatch[curIdx];
			ctrlPkg::AluExecute: return ctrlPkg::AluWriteback;
			ctrlPkg::LoadAddr: return ctrlPkg::MemRead;
			ctrlPkg::MemRead: return prevAck ? ctrlPkg::LoadWriteback : ctrlPkg::MemRead;
			ctrlPkg::StoreAddr: return ctrlPkg::MemWrite;
			ctrlPkg::MemWrite: return prevAck ? ctrlPkg::Fetch : ctrlPkg::MemWrite;
			ctrlPkg::Halt: return ctrlPkg::Halt;
			default: return ctrlPkg::Fetch; // one-cycle states
		endcase
	endfunction

	task automatic checkStep();
		logic busState;
		busState = state == ctrlPkg::Fetch || state == ctrlPkg::MemRead
			|| state == ctrlPkg::MemWrite;
		if (prevReset)
			checkValue("state after reset", int'(ctrlPkg::ResetState), int'(state));
		else
			checkValue("next state", int'(expectedNext()), int'(state));
		if (state == ctrlPkg::ResetState)
			checkValue("outputs in ResetState", 0, int'(outBits));
		checkValue("wbCyc", int'(busState), int'(wbCyc));
		checkValue("wbStb", int'(busState), int'(wbStb));
		checkValue("wbWe", int'(state == ctrlPkg::MemWrite), int'(wbWe));
		checkValue("irWrite", int'(state == ctrlPkg::Fetch && wbAck), int'(irWrite));
		checkValue("mdrControl", int'(state == ctrlPkg::MemRead && wbAck), int'(mdrControl));
		checkValue("pcControl", int'((state == ctrlPkg::Fetch && wbAck)
			|| state == ctrlPkg::Jump), int'(pcControl));
		checkValue("regWrite", int'(state == ctrlPkg::AluWriteback
			|| state == ctrlPkg::LoadWriteback), int'(regWrite));
		checkValue("writeA", int'(state == ctrlPkg::Decode), int'(writeA));
		checkValue("writeB", int'(state == ctrlPkg::Decode || state == ctrlPkg::MemWrite),
			int'(writeB));
		checkValue("aluSrcA", int'(state inside {ctrlPkg::AluExecute,
			ctrlPkg::Branch, ctrlPkg::LoadAddr, ctrlPkg::StoreAddr}), int'(aluSrcA)); // register A
		checkValue("regAluControl", int'(state inside {ctrlPkg::Decode,
			ctrlPkg::AluExecute, ctrlPkg::LoadAddr, ctrlPkg::StoreAddr}),
			int'(regAluControl));
		case (state)
			ctrlPkg::Fetch:
			begin
				checkValue("aluControl", 1, int'(aluControl)); // pc + 4
				checkValue("aluSrcB", 1, int'(aluSrcB));
			end
			ctrlPkg::Decode:
			begin
				checkValue("aluControl", 1, int'(aluControl)); // branch target
				checkValue("aluSrcB", 3, int'(aluSrcB));
			end
			ctrlPkg::AluExecute: checkValue("aluControl", int'(aluCodes[curIdx]), int'(aluControl));
			ctrlPkg::AluWriteback:
			begin
				checkValue("regDst", 1, int'(regDst)); // rd
				checkValue("memToReg", 0, int'(memToReg));
			end
			ctrlPkg::Branch:
			begin
				checkValue("pcCond", 1, int'(pcCond));
				checkValue("origPc", 1, int'(origPc));
				checkValue("aluControl", 2, int'(aluControl));
				checkValue("bneOrBeq", int'(opcodes[curIdx] == `OP_BEQ), int'(bneOrBeq));
			end
			ctrlPkg::Jump: checkValue("origPc", 2, int'(origPc));
			ctrlPkg::LoadAddr, ctrlPkg::StoreAddr:
			begin
				checkValue("aluControl", 1, int'(aluControl)); // base + offset
				checkValue("aluSrcB", 2, int'(aluSrcB));
			end
			ctrlPkg::MemRead, ctrlPkg::MemWrite: checkValue("iorD", 1, int'(iorD));
			ctrlPkg::LoadWriteback:
			begin
				checkValue("regDst", 0, int'(regDst)); // rt
				checkValue("memToReg", 1, int'(memToReg));
			end
			default:
			begin
			end
		endcase
	endtask

	// mid-cycle sampling, all inputs settled
	always @(negedge clk)
	begin
		if (reset)
		begin
			checkValue("state in reset", int'(ctrlPkg::ResetState), int'(state));
			checkValue("outputs in reset", 0, int'(outBits));
		end
		else
			checkStep();
		prevReset = reset;
		prevState = state;
		prevAck = wbAck;
		fetchDone = irWrite;
	end

	task automatic applyReset();
		reset = 1'b1;
		curIdx = -1;
		repeat (2) @(posedge clk);
		#1;
		reset = 1'b0;
	endtask

	task automatic runInstructions(input int first, input int last);
		for (int i = first; i <= last; i++)
		begin
			@(posedge clk);
			while (!fetchDone)
				@(posedge clk);
			#1;
			curIdx = i; // IR now holds word i
			opcode = opcodes[i];
			funct = functs[i];
			shamt = shamts[i];
		end
	endtask

	task automatic holdInHalt();
		while (state != ctrlPkg::Halt)
			@(posedge clk);
		repeat (5) @(posedge clk); // bus must stay idle
		#1;
	endtask

	initial
	begin
		reset = 1'b1;
		opcode = '0;
		funct = '0;
		shamt = '0;
		buildProgram();
		applyReset();
		runInstructions(0, phaseEnd);
		holdInHalt();
		applyReset();
		runInstructions(phaseEnd + 1, names.size() - 1);
		holdInHalt();
		$display("checks: %0d, errors: %0d", checkCount, errorCount);
		if (errorCount == 0)
			$display("Verification passed");
		else
			$display("Verification failed");
		$finish;
	end

endmodule

// ==== testbench/wbMemModel.sv ====
module wbMemModel
#(
	parameter int Seed = 34294
)
(
	input  logic clk,
	input  logic reset,
	input  logic wbCyc,
	input  logic wbStb,
	output logic wbAck
);

	logic [31:0] lcgState;
	logic busy;
	int waitLeft;

	function automatic logic [31:0] lcgNext(input logic [31:0] current);
		return current * 32'd1103515245 + 32'd12345;
	endfunction

	initial
	begin
		lcgState = Seed;
		busy = 1'b0;
		waitLeft = 0;
		wbAck = 1'b0;
		forever
		begin
			@(posedge clk);
			#1;
			if (reset)
			begin
				wbAck = 1'b0;
				busy = 1'b0;
			end
			else
			begin
				if (wbAck)
				begin
					wbAck = 1'b0; // transfer closed on the last edge
					busy = 1'b0;
				end
				if (wbCyc && wbStb)
				begin
					if (!busy)
					begin
						lcgState = lcgNext(lcgState);
						waitLeft = int'(lcgState[17:16]); // 0 to 3 wait cycles
						busy = 1'b1;
					end
					else
						waitLeft = waitLeft - 1;
					if (waitLeft == 0)
						wbAck = 1'b1;
				end
			end
		end
	end

endmodule

// ==== logic/controlUnit.sv ====
`include "ctrl_defs.svh"

module controlUnit
(
	input  logic                 clk,
	input  logic                 reset,
	input  logic [`OPCODE_W-1:0] opcode,
	input  logic [`FUNCT_W-1:0]  funct,
	input  logic [`SHAMT_W-1:0]  shamt,
	input  logic                 wbAck,
	output logic                 wbCyc,
	output logic                 wbStb,
	output logic                 wbWe,
	output logic                 irWrite,
	output logic                 pcControl,
	output logic                 mdrControl,
	output ctrlPkg::addrSel      iorD,
	output logic                 writeA,
	output logic                 writeB,
	output logic                 aluSrcA,
	output ctrlPkg::aluSrcBSel   aluSrcB,
	output ctrlPkg::aluOp        aluControl,
	output logic                 regAluControl,
	output logic                 pcCond,
	output logic                 bneOrBeq,
	output ctrlPkg::pcSource     origPc,
	output logic                 regWrite,
	output ctrlPkg::regDstSel    regDst,
	output ctrlPkg::memToRegSel  memToReg,
	output ctrlPkg::ctrlState    state
);

	ctrlPkg::instrKind decKind;
	ctrlPkg::aluOp decAluOp;

	instrDecoder u_decoder
	(
		.opcode(opcode),
		.funct(funct),
		.shamt(shamt),
		.kind(decKind),
		.aluOp(decAluOp)
	);

	controlSequencer u_sequencer
	(
		.clk(clk),
		.reset(reset),
		.kind(decKind),
		.wbAck(wbAck),
		.state(state),
		.wbCyc(wbCyc),
		.wbStb(wbStb),
		.wbWe(wbWe),
		.irWrite(irWrite),
		.pcControl(pcControl),
		.mdrControl(mdrControl)
	);

	datapathSelect u_select
	(
		.state(state),
		.kind(decKind),
		.aluOp(decAluOp),
		.iorD(iorD),
		.writeA(writeA),
		.writeB(writeB),
		.aluSrcA(aluSrcA),
		.aluSrcB(aluSrcB),
		.aluControl(aluControl),
		.regAluControl(regAluControl),
		.pcCond(pcCond),
		.bneOrBeq(bneOrBeq),
		.origPc(origPc),
		.regWrite(regWrite),
		.regDst(regDst),
		.memToReg(memToReg)
	);

endmodule

// ==== logic/datapathSelect.sv ====
module datapathSelect
(
	input  ctrlPkg::ctrlState  state,
	input  ctrlPkg::instrKind  kind,
	input  ctrlPkg::aluOp      aluOp,
	output ctrlPkg::addrSel    iorD,
	output logic               writeA,
	output logic               writeB,
	output logic               aluSrcA,
	output ctrlPkg::aluSrcBSel aluSrcB,
	output ctrlPkg::aluOp      aluControl,
	output logic               regAluControl,
	output logic               pcCond,
	output logic               bneOrBeq,
	output ctrlPkg::pcSource   origPc,
	output logic               regWrite,
	output ctrlPkg::regDstSel  regDst,
	output ctrlPkg::memToRegSel memToReg
);

	always_comb
	begin
		iorD = ctrlPkg::addrPc;
		writeA = 1'b0;
		writeB = 1'b0;
		aluSrcA = 1'b0; // 0 pc, 1 register A
		aluSrcB = ctrlPkg::srcBReg;
		aluControl = ctrlPkg::aluNone;
		regAluControl = 1'b0;
		pcCond = 1'b0;
		bneOrBeq = 1'b0;
		origPc = ctrlPkg::pcSeq;
		regWrite = 1'b0;
		regDst = ctrlPkg::dstRt;
		memToReg = ctrlPkg::wbAlu;
		case (state)
			ctrlPkg::Fetch:
			begin
				aluControl = ctrlPkg::aluAdd; // pc + 4
				aluSrcB = ctrlPkg::srcBFour;
			end
			ctrlPkg::Decode:
			begin
				// branch target computed early, operands latched
				aluControl = ctrlPkg::aluAdd;
				aluSrcB = ctrlPkg::srcBBranchOff;
				regAluControl = 1'b1;
				writeA = 1'b1;
				writeB = 1'b1;
			end
			ctrlPkg::AluExecute:
			begin
				aluControl = aluOp;
				aluSrcA = 1'b1;
				regAluControl = 1'b1;
			end
			ctrlPkg::AluWriteback:
			begin
				regWrite = 1'b1;
				regDst = ctrlPkg::dstRd;
				memToReg = ctrlPkg::wbAlu;
			end
			ctrlPkg::Branch:
			begin
				pcCond = 1'b1;
				origPc = ctrlPkg::pcBranch;
				aluControl = ctrlPkg::aluSub; // compare rs and rt
				aluSrcA = 1'b1;
				bneOrBeq = (kind == ctrlPkg::kindBeq);
			end
			ctrlPkg::Jump: origPc = ctrlPkg::pcJump;
			ctrlPkg::LoadAddr, ctrlPkg::StoreAddr:
			begin
				aluControl = ctrlPkg::aluAdd; // base + offset
				aluSrcA = 1'b1;
				aluSrcB = ctrlPkg::srcBImm;
				regAluControl = 1'b1;
			end
			ctrlPkg::MemRead: iorD = ctrlPkg::addrAlu;
			ctrlPkg::MemWrite:
			begin
				iorD = ctrlPkg::addrAlu;
				writeB = 1'b1;
			end
			ctrlPkg::LoadWriteback:
			begin
				regWrite = 1'b1;
				regDst = ctrlPkg::dstRt;
				memToReg = ctrlPkg::wbMem;
			end
			default:
			begin
			end
		endcase
	end

endmodule

// ==== logic/controlSequencer.sv ====
module controlSequencer
(
	input  logic              clk,
	input  logic              reset,
	input  ctrlPkg::instrKind kind,
	input  logic              wbAck,
	output ctrlPkg::ctrlState state,
	output logic              wbCyc,
	output logic              wbStb,
	output logic              wbWe,
	output logic              irWrite,
	output logic              pcControl,
	output logic              mdrControl
);

	ctrlPkg::ctrlState nextState;
	logic busState;

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
			state <= ctrlPkg::ResetState;
		else
			state <= nextState;
	end

	always_comb
	begin
		nextState = state; // bus states hold here until ack
		case (state)
			ctrlPkg::ResetState: nextState = ctrlPkg::Fetch;
			ctrlPkg::Fetch:
			begin
				if (wbAck)
					nextState = ctrlPkg::Decode;
			end
			ctrlPkg::Decode:
			begin
				case (kind)
					ctrlPkg::kindAlu: nextState = ctrlPkg::AluExecute;
					ctrlPkg::kindBeq: nextState = ctrlPkg::Branch;
					ctrlPkg::kindBne: nextState = ctrlPkg::Branch;
					ctrlPkg::kindLw: nextState = ctrlPkg::LoadAddr;
					ctrlPkg::kindSw: nextState = ctrlPkg::StoreAddr;
					ctrlPkg::kindJ: nextState = ctrlPkg::Jump;
					ctrlPkg::kindNop: nextState = ctrlPkg::Nop;
					default: nextState = ctrlPkg::Halt; // break and anything undecoded
				endcase
			end
			ctrlPkg::AluExecute: nextState = ctrlPkg::AluWriteback;
			ctrlPkg::AluWriteback: nextState = ctrlPkg::Fetch;
			ctrlPkg::Branch: nextState = ctrlPkg::Fetch;
			ctrlPkg::Jump: nextState = ctrlPkg::Fetch;
			ctrlPkg::Nop: nextState = ctrlPkg::Fetch;
			ctrlPkg::LoadAddr: nextState = ctrlPkg::MemRead;
			ctrlPkg::MemRead:
			begin
				if (wbAck)
					nextState = ctrlPkg::LoadWriteback;
			end
			ctrlPkg::LoadWriteback: nextState = ctrlPkg::Fetch;
			ctrlPkg::StoreAddr: nextState = ctrlPkg::MemWrite;
			ctrlPkg::MemWrite:
			begin
				if (wbAck)
					nextState = ctrlPkg::Fetch;
			end
			ctrlPkg::Halt: nextState = ctrlPkg::Halt; // left only by reset
			default: nextState = ctrlPkg::ResetState;
		endcase
	end

	// one classic cycle per bus state
	assign busState = (state == ctrlPkg::Fetch) || (state == ctrlPkg::MemRead)
		|| (state == ctrlPkg::MemWrite);

	assign wbCyc = busState;
	assign wbStb = busState;
	assign wbWe = (state == ctrlPkg::MemWrite);

	// latch enables fire in the ack cycle only
	assign irWrite = (state == ctrlPkg::Fetch) && wbAck;
	assign mdrControl = (state == ctrlPkg::MemRead) && wbAck;
	assign pcControl = ((state == ctrlPkg::Fetch) && wbAck) || (state == ctrlPkg::Jump);

endmodule

// ==== logic/instrDecoder.sv ====
`include "ctrl_defs.svh"

module instrDecoder
(
	input  logic [`OPCODE_W-1:0] opcode,
	input  logic [`FUNCT_W-1:0]  funct,
	input  logic [`SHAMT_W-1:0]  shamt,
	output ctrlPkg::instrKind    kind,
	output ctrlPkg::aluOp        aluOp
);

	always_comb
	begin
		kind = ctrlPkg::kindUnsupported;
		aluOp = ctrlPkg::aluNone;
		case (opcode)
			`OP_RTYPE:
			begin
				case (funct)
					`FN_ADD:
					begin
						kind = ctrlPkg::kindAlu;
						aluOp = ctrlPkg::aluAdd;
					end
					`FN_SUB:
					begin
						kind = ctrlPkg::kindAlu;
						aluOp = ctrlPkg::aluSub;
					end
					`FN_AND:
					begin
						kind = ctrlPkg::kindAlu;
						aluOp = ctrlPkg::aluAnd;
					end
					`FN_XOR:
					begin
						kind = ctrlPkg::kindAlu;
						aluOp = ctrlPkg::aluXor;
					end
					`FN_BREAK: kind = ctrlPkg::kindBreak;
					`FN_SLL:
					begin
						// only the all-zero shift is kept
						if (shamt == '0)
							kind = ctrlPkg::kindNop;
					end
					default: kind = ctrlPkg::kindUnsupported;
				endcase
			end
			`OP_BEQ: kind = ctrlPkg::kindBeq;
			`OP_BNE: kind = ctrlPkg::kindBne;
			`OP_LW: kind = ctrlPkg::kindLw;
			`OP_SW: kind = ctrlPkg::kindSw;
			`OP_J: kind = ctrlPkg::kindJ;
			default: kind = ctrlPkg::kindUnsupported;
		endcase
	end

endmodule

// ==== logic/ctrlPkg.sv ====
package ctrlPkg;

	typedef enum logic [3:0] {
		kindAlu,
		kindBeq,
		kindBne,
		kindLw,
		kindSw,
		kindJ,
		kindNop,
		kindBreak,
		kindUnsupported
	} instrKind;

	typedef enum logic [3:0] {
		ResetState,
		Fetch,
		Decode,
		AluExecute,
		AluWriteback,
		Branch,
		Jump,
		LoadAddr,
		MemRead,
		LoadWriteback,
		StoreAddr,
		MemWrite,
		Nop,
		Halt
	} ctrlState;

	// ALU function codes as the datapath ALU expects them
	typedef enum logic [2:0] {
		aluNone = 3'b000,
		aluAdd  = 3'b001,
		aluSub  = 3'b010,
		aluAnd  = 3'b011,
		aluXor  = 3'b110
	} aluOp;

	typedef enum logic [1:0] {pcSeq = 2'd0, pcBranch = 2'd1, pcJump = 2'd2} pcSource;

	typedef enum logic [1:0] {
		srcBReg       = 2'd0,
		srcBFour      = 2'd1,
		srcBImm       = 2'd2,
		srcBBranchOff = 2'd3
	} aluSrcBSel;

	typedef enum logic {dstRt = 1'b0, dstRd = 1'b1} regDstSel;
	typedef enum logic {wbAlu = 1'b0, wbMem = 1'b1} memToRegSel;
	typedef enum logic {addrPc = 1'b0, addrAlu = 1'b1} addrSel;

endpackage

// ==== logic/ctrl_defs.svh ====
`ifndef CTRL_DEFS_SVH
`define CTRL_DEFS_SVH

// instruction field widths
`define OPCODE_W 6
`define FUNCT_W  6
`define SHAMT_W  5

// opcodes
`define OP_RTYPE 6'h00
`define OP_J     6'h02
`define OP_BEQ   6'h04
`define OP_BNE   6'h05
`define OP_LW    6'h23
`define OP_SW    6'h2b

// R-type funct codes
`define FN_SLL   6'h00 // sll with shamt zero is nop
`define FN_BREAK 6'h0d
`define FN_ADD   6'h20
`define FN_SUB   6'h22
`define FN_AND   6'h24
`define FN_XOR   6'h26

`endif
